/* hw/wiener_pkg.sv */
// wiener denoise shared definitions
package wiener_pkg;

	localparam int BLOCK_SAMPLES = 16;
	localparam int BLOCK_SHIFT   = 4;   // log2 of block size
	localparam int PIX_W         = 8;
	localparam int VAR_W         = 16;
	localparam int BPF_W         = 16;  // blocks per frame field
	localparam int SUM_W         = PIX_W + BLOCK_SHIFT;
	localparam int SQ_W          = 2 * PIX_W + BLOCK_SHIFT;

	// axi4-lite sizing and register map
	localparam int AXI_ADDR_W = 8;
	localparam int AXI_DATA_W = 32;
	localparam logic [AXI_ADDR_W-1:0] ADDR_BLOCKS = 8'h00;
	localparam logic [AXI_ADDR_W-1:0] ADDR_NOISE  = 8'h04;
	localparam logic [AXI_ADDR_W-1:0] ADDR_FRAMES = 8'h08;

	typedef logic [PIX_W-1:0] pix_t;

	typedef struct packed {
		pix_t             mean;
		logic [VAR_W-1:0] variance;
	} block_stats_t;

	typedef struct packed {
		logic [BPF_W-1:0] blocks_per_frame;
		logic [VAR_W-1:0] noise_var;
	} wiener_cfg_t;

	typedef struct packed {
		logic take_pixel;   // new pixel into sums and delay line
		logic drain_pixel;  // shift only
		logic clear_accum;
		logic latch_stats;
	} block_ctl_t;

endpackage

/* hw/wiener_csr.sv */
// configuration and status registers
module wiener_csr (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                awvalid,
	output logic                                awready,
	input  logic [wiener_pkg::AXI_ADDR_W-1:0]   awaddr,
	input  logic                                wvalid,
	output logic                                wready,
	input  logic [wiener_pkg::AXI_DATA_W-1:0]   wdata,
	output logic                                bvalid,
	input  logic                                bready,
	output logic [1:0]                          bresp,
	input  logic                                arvalid,
	output logic                                arready,
	input  logic [wiener_pkg::AXI_ADDR_W-1:0]   araddr,
	output logic                                rvalid,
	input  logic                                rready,
	output logic [wiener_pkg::AXI_DATA_W-1:0]   rdata,
	output logic [1:0]                          rresp,
	input  logic                                frame_done,
	output wiener_pkg::wiener_cfg_t             cfg
);
	import wiener_pkg::*;

	logic                  wr_fire;
	logic                  rd_fire;
	logic [AXI_DATA_W-1:0] frame_cnt;

	// aw and w taken together, one write in flight
	assign awready = awvalid && wvalid && !bvalid;
	assign wready  = awready;
	assign wr_fire = awready;
	assign bresp   = 2'b00;

	assign arready = arvalid && !rvalid;
	assign rd_fire = arready;
	assign rresp   = 2'b00;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg    <= '0;
			bvalid <= 1'b0;
		end else begin
			if (wr_fire) begin
				bvalid <= 1'b1;
				case (awaddr)
					ADDR_BLOCKS: cfg.blocks_per_frame <= wdata[BPF_W-1:0];
					ADDR_NOISE:  cfg.noise_var <= wdata[VAR_W-1:0];
					default: ;  // frame counter is read only
				endcase
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_cnt <= '0;
		end else if (frame_done) begin
			frame_cnt <= frame_cnt + AXI_DATA_W'(1);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else if (rd_fire) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// read data, unmapped addresses give zero
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			case (araddr)
				ADDR_BLOCKS: rdata <= AXI_DATA_W'(cfg.blocks_per_frame);
				ADDR_NOISE:  rdata <= AXI_DATA_W'(cfg.noise_var);
				ADDR_FRAMES: rdata <= frame_cnt;
				default:     rdata <= '0;
			endcase
		end
	end

endmodule

/* hw/wiener_block_stats_fsm.sv */
// block statistics sequencer
module wiener_block_stats_fsm (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          sof,
	input  logic                          pix_valid,
	output logic                          pix_ready,
	input  logic                          stats_valid,
	input  logic [wiener_pkg::BPF_W-1:0]  blocks_per_frame,
	output wiener_pkg::block_ctl_t        ctl,
	output logic                          replay_active,
	output logic                          frame_done
);
	import wiener_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		READ,
		WAIT_STATS,
		DRAIN
	} state_t;

	state_t                 state;
	state_t                 state_nxt;
	logic [BLOCK_SHIFT-1:0] smp_cnt;     // wraps to zero after a block
	logic [BPF_W-1:0]       blk_cnt;
	logic [BPF_W-1:0]       blk_target;
	logic                   last_smp;
	logic                   last_blk;

	// zero blocks per frame behaves as one
	assign blk_target = (blocks_per_frame == '0) ? BPF_W'(1) : blocks_per_frame;
	assign last_smp   = smp_cnt == BLOCK_SHIFT'(BLOCK_SAMPLES - 1);
	assign last_blk   = (blk_cnt + BPF_W'(1)) == blk_target;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (sof)
					state_nxt = READ;
			end
			READ: begin
				if (ctl.take_pixel && last_smp)
					state_nxt = WAIT_STATS;
			end
			WAIT_STATS: begin
				if (stats_valid)
					state_nxt = last_blk ? DRAIN : READ;
			end
			DRAIN: begin
				if (last_smp)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	assign pix_ready       = state == READ;
	assign ctl.take_pixel  = pix_ready && pix_valid;
	assign ctl.drain_pixel = state == DRAIN;
	assign ctl.latch_stats = (state == WAIT_STATS) && stats_valid;
	assign ctl.clear_accum = (state != READ) && (state_nxt == READ); // entry to READ

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= IDLE;
			smp_cnt       <= '0;
			blk_cnt       <= '0;
			replay_active <= 1'b0;
			frame_done    <= 1'b0;
		end else begin
			state      <= state_nxt;
			frame_done <= (state == DRAIN) && last_smp;

			if (state == IDLE && sof) begin
				smp_cnt <= '0;
				blk_cnt <= '0;
			end else begin
				if (ctl.take_pixel || ctl.drain_pixel)
					smp_cnt <= smp_cnt + BLOCK_SHIFT'(1);
				if (ctl.latch_stats)
					blk_cnt <= blk_cnt + BPF_W'(1);
			end

			// replay runs from the first latched block to the end of drain
			if (ctl.latch_stats)
				replay_active <= 1'b1;
			else if (state == DRAIN && last_smp)
				replay_active <= 1'b0;
		end
	end

endmodule

/* hw/block_stats_accum.sv */
// block mean and variance accumulator
module block_stats_accum (
	input  logic                     clk,
	input  logic                     rst_n,
	input  wiener_pkg::block_ctl_t   ctl,
	input  wiener_pkg::pix_t         pix_in,
	output logic                     stats_valid,
	output wiener_pkg::block_stats_t stats
);
	import wiener_pkg::*;

	logic [SUM_W-1:0]       sum;
	logic [SQ_W-1:0]        sq_sum;
	logic [BLOCK_SHIFT-1:0] cnt;
	logic                   sums_done;   // stage 1 holds a full block
	pix_t                   mean_c;
	logic [VAR_W-1:0]       sq_mean_c;
	logic [VAR_W-1:0]       mean_sq_c;

	assign mean_c    = sum[SUM_W-1:BLOCK_SHIFT];      // truncated mean
	assign sq_mean_c = sq_sum[SQ_W-1:BLOCK_SHIFT];
	assign mean_sq_c = VAR_W'(mean_c) * VAR_W'(mean_c);

	always_ff @(posedge clk) begin
		if (ctl.clear_accum) begin
			sum    <= '0;
			sq_sum <= '0;
		end else if (ctl.take_pixel) begin
			sum    <= sum + SUM_W'(pix_in);
			sq_sum <= sq_sum + SQ_W'(pix_in) * SQ_W'(pix_in);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt         <= '0;
			sums_done   <= 1'b0;
			stats_valid <= 1'b0;
		end else begin
			sums_done   <= ctl.take_pixel && (cnt == BLOCK_SHIFT'(BLOCK_SAMPLES - 1));
			stats_valid <= sums_done;
			if (ctl.clear_accum)
				cnt <= '0;
			else if (ctl.take_pixel)
				cnt <= cnt + BLOCK_SHIFT'(1);
		end
	end

	// stage 2, variance floored at zero
	always_ff @(posedge clk) begin
		if (sums_done) begin
			stats.mean     <= mean_c;
			stats.variance <= (sq_mean_c > mean_sq_c) ? sq_mean_c - mean_sq_c : '0;
		end
	end

endmodule

/* hw/block_delay_line.sv */
// block delay line
module block_delay_line (
	input  logic                   clk,
	input  logic                   rst_n,
	input  wiener_pkg::block_ctl_t ctl,
	input  wiener_pkg::pix_t       pix_in,
	output wiener_pkg::pix_t       pix_out
);
	import wiener_pkg::*;

	pix_t taps [BLOCK_SAMPLES];

	assign pix_out = taps[BLOCK_SAMPLES-1];  // oldest pixel

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < BLOCK_SAMPLES; i++)
				taps[i] <= '0;
		end else if (ctl.take_pixel || ctl.drain_pixel) begin
			taps[0] <= ctl.take_pixel ? pix_in : '0;  // drain pushes zeros
			for (int i = 1; i < BLOCK_SAMPLES; i++)
				taps[i] <= taps[i-1];
		end
	end

endmodule

/* hw/wiener_gain_apply.sv */
// wiener gain stage
module wiener_gain_apply (
	input  logic                         clk,
	input  logic                         rst_n,
	input  wiener_pkg::block_ctl_t       ctl,
	input  logic                         replay_active,
	input  wiener_pkg::block_stats_t     stats,
	input  logic [wiener_pkg::VAR_W-1:0] noise_var,
	input  wiener_pkg::pix_t             pix_in,
	output logic                         out_valid,
	output wiener_pkg::pix_t             out_pix
);
	import wiener_pkg::*;

	localparam int PROD_W = VAR_W + PIX_W + 2;

	block_stats_t              stats_q;    // block being replayed
	logic                      shift_ok;
	logic signed [VAR_W:0]     gain_num;
	logic signed [PIX_W:0]     dev;
	logic signed [PROD_W-1:0]  prod;
	logic signed [PROD_W-1:0]  quot;
	logic signed [PROD_W-1:0]  res;
	pix_t                      pix_new;

	assign shift_ok = (ctl.take_pixel || ctl.drain_pixel) && replay_active;

	always_comb begin
		gain_num = $signed({1'b0, stats_q.variance}) - $signed({1'b0, noise_var});
		dev      = $signed({1'b0, pix_in}) - $signed({1'b0, stats_q.mean});
		prod     = gain_num * dev;
		// signed divide truncates toward zero
		quot     = prod / $signed({{(PROD_W - VAR_W){1'b0}}, stats_q.variance});
		res      = quot + $signed({{(PROD_W - PIX_W){1'b0}}, stats_q.mean});
		if (stats_q.variance <= noise_var)
			pix_new = stats_q.mean;  // block is all noise
		else if (res < 0)
			pix_new = '0;
		else if (res > PROD_W'(255))
			pix_new = 8'hff;
		else
			pix_new = res[PIX_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (ctl.latch_stats)
			stats_q <= stats;
		if (shift_ok)
			out_pix <= pix_new;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= shift_ok;
	end

endmodule

/* hw/wiener_top.sv */
// wiener denoise top level
module wiener_top (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                sof,
	input  logic                                pix_valid,
	input  wiener_pkg::pix_t                    pix_in,
	output logic                                pix_ready,
	output logic                                out_valid,
	output wiener_pkg::pix_t                    out_pix,
	input  logic                                awvalid,
	output logic                                awready,
	input  logic [wiener_pkg::AXI_ADDR_W-1:0]   awaddr,
	input  logic                                wvalid,
	output logic                                wready,
	input  logic [wiener_pkg::AXI_DATA_W-1:0]   wdata,
	output logic                                bvalid,
	input  logic                                bready,
	output logic [1:0]                          bresp,
	input  logic                                arvalid,
	output logic                                arready,
	input  logic [wiener_pkg::AXI_ADDR_W-1:0]   araddr,
	output logic                                rvalid,
	input  logic                                rready,
	output logic [wiener_pkg::AXI_DATA_W-1:0]   rdata,
	output logic [1:0]                          rresp
);
	import wiener_pkg::*;

	wiener_cfg_t  cfg;
	block_ctl_t   ctl;
	block_stats_t stats;
	pix_t         delayed_pix;  // current block replayed
	logic         stats_valid;
	logic         replay_active;
	logic         frame_done;

	wiener_csr i_csr (
		.clk, .rst_n,
		.awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
		.frame_done, .cfg
	);

	wiener_block_stats_fsm i_fsm (
		.clk, .rst_n, .sof, .pix_valid, .pix_ready, .stats_valid,
		.blocks_per_frame (cfg.blocks_per_frame),
		.ctl, .replay_active, .frame_done
	);

	block_stats_accum i_accum (
		.clk, .rst_n, .ctl, .pix_in, .stats_valid, .stats
	);

	block_delay_line i_delay (
		.clk, .rst_n, .ctl, .pix_in, .pix_out (delayed_pix)
	);

	wiener_gain_apply i_gain (
		.clk, .rst_n, .ctl, .replay_active, .stats,
		.noise_var (cfg.noise_var),
		.pix_in    (delayed_pix),
		.out_valid, .out_pix
	);

endmodule

/* verification/wiener_checker.sv */
// output and register checker
module wiener_checker (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              sof,
	input  logic                              pix_valid,
	input  logic                              pix_ready,
	input  wiener_pkg::pix_t                  pix_in,
	input  logic                              out_valid,
	input  wiener_pkg::pix_t                  out_pix,
	input  logic                              arvalid,
	input  logic                              arready,
	input  logic [wiener_pkg::AXI_ADDR_W-1:0] araddr,
	input  logic                              rvalid,
	input  logic                              rready,
	input  logic [wiener_pkg::AXI_DATA_W-1:0] rdata,
	input  logic [1:0]                        rresp,
	input  logic [wiener_pkg::AXI_DATA_W-1:0] reg_expect,
	input  logic [8*12-1:0]                   test_name,
	input  logic [wiener_pkg::VAR_W-1:0]      noise_var,
	output int                                pending,
	output int                                pix_errors,
	output int                                reg_errors
);
	import wiener_pkg::*;

	int                    blk_q [$];   // pixels of the block being read
	int                    exp_q [$];   // expected outputs, in order
	int                    out_cnt;
	logic [AXI_ADDR_W-1:0] rd_addr;

	// wiener rule for one pixel, truncation toward zero then clamp
	function automatic int gain_model(int pix, int mean, int blk_var, int noise);
		int res;
		if (blk_var <= noise)
			return mean;
		res = mean + ((blk_var - noise) * (pix - mean)) / blk_var;
		if (res < 0)
			res = 0;
		else if (res > 255)
			res = 255;
		return res;
	endfunction

	task automatic close_block();
		int sum;
		int sq_sum;
		int mean;
		int blk_var;
		sum    = 0;
		sq_sum = 0;
		foreach (blk_q[i]) begin
			sum    += blk_q[i];
			sq_sum += blk_q[i] * blk_q[i];
		end
		mean    = sum / BLOCK_SAMPLES;
		blk_var = sq_sum / BLOCK_SAMPLES - mean * mean;
		if (blk_var < 0)
			blk_var = 0;
		foreach (blk_q[i])
			exp_q.push_back(gain_model(blk_q[i], mean, blk_var, int'(noise_var)));
		blk_q.delete();
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			blk_q.delete();
			exp_q.delete();
			out_cnt    = 0;
			rd_addr    <= '0;
			pending    <= 0;
			pix_errors <= 0;
			reg_errors <= 0;
		end else begin
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					$display("%s: output pixel %0d arrived with none expected", test_name,
						out_cnt);
					pix_errors <= pix_errors + 1;
				end else if (int'(out_pix) != exp_q[0]) begin
					$display("Mismatch %s pixel %0d: expected %0d actual %0d", test_name,
						out_cnt, exp_q[0], out_pix);
					pix_errors <= pix_errors + 1;
				end
				if (exp_q.size() != 0)
					void'(exp_q.pop_front());
				out_cnt++;
			end
			if (sof)
				blk_q.delete();  // new frame starts a fresh block
			if (pix_valid && pix_ready) begin
				blk_q.push_back(int'(pix_in));
				if (blk_q.size() == BLOCK_SAMPLES)
					close_block();
			end
			if (arvalid && arready)
				rd_addr <= araddr;
			if (rvalid && rready) begin
				if (rdata != reg_expect) begin
					$display("Mismatch %s register 0x%02h: expected 0x%08h actual 0x%08h",
						test_name, rd_addr, reg_expect, rdata);
					reg_errors <= reg_errors + 1;
				end
				if (rresp != 2'b00) begin
					$display("Mismatch %s register 0x%02h response: expected 0 actual %0d",
						test_name, rd_addr, rresp);
					reg_errors <= reg_errors + 1;
				end
			end
			pending <= exp_q.size();
		end
	end

endmodule

/* verification/tb_wiener_top.sv */
// wiener denoise testbench
module tb_wiener_top;
	import wiener_pkg::*;

	typedef enum logic [1:0] {
		PAT_FLAT,
		PAT_RAND,
		PAT_EXTREME
	} pattern_t;

	typedef struct packed {
		logic [8*12-1:0] name;
		logic [15:0]     blocks;
		logic [15:0]     noise;
		pattern_t        pattern;
		logic [7:0]      gap_pct;   // chance of an idle input cycle
	} test_t;

	test_t tbl [9] = '{
		'{"flat",       16'd2, 16'd40,    PAT_FLAT,    8'd0},
		'{"noise_high", 16'd2, 16'd30000, PAT_RAND,    8'd0},
		'{"zero_noise", 16'd2, 16'd0,     PAT_RAND,    8'd10},
		'{"mid_noise",  16'd3, 16'd1500,  PAT_RAND,    8'd0},
		'{"extreme",    16'd2, 16'd3000,  PAT_EXTREME, 8'd0},
		'{"gaps",       16'd4, 16'd800,   PAT_RAND,    8'd45},
		'{"b2b_one",    16'd1, 16'd500,   PAT_EXTREME, 8'd20},
		'{"b2b_zero",   16'd0, 16'd2000,  PAT_RAND,    8'd0},
		'{"b2b_three",  16'd3, 16'd100,   PAT_FLAT,    8'd30}
	};

	logic                  clk;
	logic                  rst_n;
	logic                  sof;
	logic                  pix_valid;
	pix_t                  pix_in;
	logic                  pix_ready;
	logic                  out_valid;
	pix_t                  out_pix;
	logic                  awvalid, awready, wvalid, wready, bvalid, bready;
	logic                  arvalid, arready, rvalid, rready;
	logic [AXI_ADDR_W-1:0] awaddr, araddr;
	logic [AXI_DATA_W-1:0] wdata, rdata, reg_expect;
	logic [1:0]            bresp, rresp;
	logic [8*12-1:0]       cur_name;
	logic [VAR_W-1:0]      cur_noise;
	int                    pending, pix_errors, reg_errors;
	int                    other_errors;
	pix_t                  frame_pix [$];

	wiener_top i_dut (.*);

	wiener_checker i_check (
		.clk, .rst_n, .sof, .pix_valid, .pix_ready, .pix_in, .out_valid, .out_pix,
		.arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp, .reg_expect,
		.test_name (cur_name),
		.noise_var (cur_noise),
		.pending, .pix_errors, .reg_errors
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
		awvalid <= 1'b1;
		awaddr  <= addr;
		wvalid  <= 1'b1;
		wdata   <= data;
		bready  <= 1'b1;
		do
			@(posedge clk);
		while (!awready);
		if (!wready) begin
			$display("%s: wready did not rise with awready on write to 0x%02h", cur_name, addr);
			other_errors++;
		end
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do
			@(posedge clk);
		while (!bvalid);
		bready <= 1'b0;
		if (bresp != 2'b00) begin
			$display("%s: write to 0x%02h got an error response", cur_name, addr);
			other_errors++;
		end
	endtask

	// the checker compares rdata against reg_expect
	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] exp_data);
		arvalid    <= 1'b1;
		araddr     <= addr;
		rready     <= 1'b1;
		reg_expect <= exp_data;
		do
			@(posedge clk);
		while (!arready);
		arvalid <= 1'b0;
		do
			@(posedge clk);
		while (!rvalid);
		rready <= 1'b0;
	endtask

	task automatic build_frame(input pattern_t pat, input int nblk);
		pix_t level;
		frame_pix.delete();
		for (int b = 0; b < nblk; b++) begin
			level = 8'($urandom);
			for (int s = 0; s < BLOCK_SAMPLES; s++) begin
				case (pat)
					PAT_FLAT:    frame_pix.push_back(level);
					PAT_EXTREME: frame_pix.push_back(($urandom % 2) != 0 ? 8'hff : 8'h00);
					default:     frame_pix.push_back(8'($urandom));
				endcase
			end
		end
	endtask

	task automatic send_frame(input int gap_pct);
		int idx;
		idx = 0;
		sof <= 1'b1;
		@(posedge clk);
		sof <= 1'b0;
		while (idx < frame_pix.size()) begin
			pix_valid <= int'($urandom % 100) >= gap_pct;
			pix_in    <= frame_pix[idx];
			@(posedge clk);
			if (pix_valid && pix_ready)
				idx++;
		end
		pix_valid <= 1'b0;
	endtask

	initial begin
		int nblk;
		int frames;
		void'($urandom(32'h727c15dc));
		frames       = 0;
		other_errors = 0;
		rst_n        = 1'b0;
		sof          = 1'b0;
		pix_valid    = 1'b0;
		pix_in       = '0;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		awaddr       = '0;
		araddr       = '0;
		wdata        = '0;
		reg_expect   = '0;
		cur_name     = "reset";
		cur_noise    = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		if (pix_ready || out_valid) begin
			$display("pix_ready or out_valid is high right after reset");
			other_errors++;
		end
		axi_read(ADDR_BLOCKS, 32'd0);
		axi_read(ADDR_NOISE, 32'd0);
		axi_read(ADDR_FRAMES, 32'd0);
		axi_read(8'h0c, 32'd0);  // unmapped

		for (int t = 0; t < $size(tbl); t++) begin
			cur_name  <= tbl[t].name;
			cur_noise <= tbl[t].noise;
			nblk = (tbl[t].blocks == 16'd0) ? 1 : int'(tbl[t].blocks);
			axi_write(ADDR_BLOCKS, 32'(tbl[t].blocks));
			axi_write(ADDR_NOISE, 32'(tbl[t].noise));
			axi_read(ADDR_BLOCKS, 32'(tbl[t].blocks));
			axi_read(ADDR_NOISE, 32'(tbl[t].noise));
			build_frame(tbl[t].pattern, nblk);
			send_frame(int'(tbl[t].gap_pct));
			do
				@(posedge clk);
			while (pending != 0);  // last block drained
			frames++;
			axi_read(ADDR_FRAMES, 32'(frames));
		end

		repeat (4) @(posedge clk);
		$display("errors: %0d pixel, %0d register, %0d other", pix_errors, reg_errors,
			other_errors);
		if (pix_errors + reg_errors + other_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog sized from the table, four cycles per pixel plus margin
	initial begin
		int limit;
		limit = 0;
		for (int t = 0; t < $size(tbl); t++)
			limit += ((tbl[t].blocks == 16'd0) ? 1 : int'(tbl[t].blocks)) * BLOCK_SAMPLES;
		limit = limit * 4 + 1000;
		repeat (limit) @(posedge clk);
		$display("timeout: run did not finish within %0d clock periods", limit);
		$display("Test failures found");
		$finish;
	end

endmodule

/* verilog.f */
hw/wiener_pkg.sv
hw/wiener_csr.sv
hw/wiener_block_stats_fsm.sv
hw/block_stats_accum.sv
hw/block_delay_line.sv
hw/wiener_gain_apply.sv
hw/wiener_top.sv
verification/wiener_checker.sv
verification/tb_wiener_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the wiener denoise testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_wiener_top -o tb_wiener_top
sim_out=$(./obj_dir/tb_wiener_top)
echo "$sim_out"
echo "$sim_out" | grep -q "All tests passed!"
